//--- rtl/stream_consts.svh
`ifndef STREAM_CONSTS_SVH
`define STREAM_CONSTS_SVH

// Host word and lite bus data width
`define STREAM_WORD_W 32

// Samples passed between processing stages
`define STREAM_SAMPLE_W 16

// Entries per FIFO
`define STREAM_FIFO_DEPTH 16

// Free entries left when almost-full rises
`define STREAM_AFULL_SLACK 4

`define STREAM_STAGES 7
`define STREAM_PACE 4

// Lite register file geometry
`define LITE_ENTRIES 32
`define LITE_LANES 4
`define LITE_ADDR_LSB 2

`define RAM_BYTES 32

`endif

//--- rtl/stream_pkg.sv
`include "stream_consts.svh"

package stream_pkg;

  typedef logic [`STREAM_WORD_W-1:0] word_t;

  typedef logic [`STREAM_SAMPLE_W-1:0] sample_t;

  typedef logic [7:0] byte_t;

  // Word index, bits 6:2 of the byte address
  typedef logic [$clog2(`LITE_ENTRIES)-1:0] lite_idx_t;

  typedef logic [$clog2(`RAM_BYTES)-1:0] ram_addr_t;

  // One offset per processing stage
  typedef sample_t [`STREAM_STAGES-1:0] offsets_t;

endpackage

//--- rtl/lite_bus_if.sv
`timescale 1ns/1ps
`include "stream_consts.svh"

interface lite_bus_if;

  logic                      wren;
  logic [`LITE_LANES-1:0]    wstrb;
  logic                      rden;
  stream_pkg::lite_idx_t     addr;
  stream_pkg::word_t         wr_data;
  stream_pkg::word_t         rd_data;

  modport host (
    output wren,
    output wstrb,
    output rden,
    output addr,
    output wr_data,
    input  rd_data
  );

  modport regs (
    input  wren,
    input  wstrb,
    input  rden,
    input  addr,
    input  wr_data,
    output rd_data
  );

endinterface

//--- rtl/sync_fifo.sv
`timescale 1ns/1ps
`include "stream_consts.svh"

module sync_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = `STREAM_FIFO_DEPTH
) (
  input  logic     bus_clk,
  input  logic     rst_n,
  input  logic     clear,
  input  logic     wr_en,
  input  payload_t din,
  input  logic     rd_en,
  output payload_t dout,
  output logic     full,
  output logic     afull,
  output logic     empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_wr;
  logic             do_rd;

  // Writes when full and reads when empty are dropped
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  assign full  = (count == CNT_W'(DEPTH));
  assign empty = (count == '0);
  assign afull = (count >= CNT_W'(DEPTH - `STREAM_AFULL_SLACK));

  always_ff @(posedge bus_clk)
  begin
    if (do_wr)
    begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge bus_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      dout   <= '0;
    end
    else if (clear)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_wr)
      begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd)
      begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        dout   <= mem[rd_ptr];
      end
      // Occupancy moves only when exactly one side is active
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- rtl/lite_regs.sv
`timescale 1ns/1ps
`include "stream_consts.svh"

module lite_regs (
  input  logic                 bus_clk,
  input  logic                 rst_n,
  lite_bus_if.regs             bus,
  output stream_pkg::offsets_t offsets
);

  // One byte array per lane
  stream_pkg::byte_t lane_mem [`LITE_LANES][`LITE_ENTRIES];

  always_ff @(posedge bus_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int l = 0; l < `LITE_LANES; l++)
      begin
        for (int e = 0; e < `LITE_ENTRIES; e++)
        begin
          lane_mem[l][e] <= '0;
        end
      end
    end
    else if (bus.wren)
    begin
      for (int l = 0; l < `LITE_LANES; l++)
      begin
        if (bus.wstrb[l])
        begin
          lane_mem[l][bus.addr] <= bus.wr_data[8*l +: 8];
        end
      end
    end
  end

  // Read data holds until the next rden
  always_ff @(posedge bus_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bus.rd_data <= '0;
    end
    else if (bus.rden)
    begin
      for (int l = 0; l < `LITE_LANES; l++)
      begin
        bus.rd_data[8*l +: 8] <= lane_mem[l][bus.addr];
      end
    end
  end

  // Stage k offset is lanes 1:0 of entry k
  always_comb
  begin
    for (int k = 0; k < `STREAM_STAGES; k++)
    begin
      offsets[k] = {lane_mem[1][k], lane_mem[0][k]};
    end
  end

endmodule

//--- rtl/byte_ram.sv
`timescale 1ns/1ps
`include "stream_consts.svh"

module byte_ram (
  input  logic                  bus_clk,
  input  logic                  rst_n,
  input  logic                  wren,
  input  stream_pkg::byte_t     wdata,
  input  logic                  rden,
  input  stream_pkg::ram_addr_t addr,
  output stream_pkg::byte_t     rdata
);

  stream_pkg::byte_t mem [`RAM_BYTES];

  always_ff @(posedge bus_clk)
  begin
    if (wren)
    begin
      mem[addr] <= wdata;
    end
  end

  // Registered read port
  always_ff @(posedge bus_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rdata <= '0;
    end
    else if (rden)
    begin
      rdata <= mem[addr];
    end
  end

endmodule

//--- rtl/input_pacer.sv
`timescale 1ns/1ps
`include "stream_consts.svh"

module input_pacer (
  input  logic bus_clk,
  input  logic rst_n,
  input  logic clear,
  input  logic empty,
  output logic rd_en,
  output logic valid
);

  localparam int PHASE_W = (`STREAM_PACE > 1) ? $clog2(`STREAM_PACE) : 1;

  logic [PHASE_W-1:0] phase;

  // One read per pacing period while data is available
  assign rd_en = !empty && (phase == '0);

  always_ff @(posedge bus_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase <= '0;
      valid <= 1'b0;
    end
    else if (clear)
    begin
      phase <= '0;
      valid <= 1'b0;
    end
    else
    begin
      valid <= rd_en;
      if (empty)
        phase <= '0;
      else if (phase == PHASE_W'(`STREAM_PACE - 1))
        phase <= '0;
      else
        phase <= phase + 1'b1;
    end
  end

endmodule

//--- rtl/offset_stage.sv
`timescale 1ns/1ps

module offset_stage (
  input  logic                bus_clk,
  input  logic                rst_n,
  input  logic                clear,
  input  logic                in_valid,
  input  stream_pkg::sample_t in_sample,
  input  stream_pkg::sample_t offset,
  output logic                out_valid,
  output stream_pkg::sample_t out_sample
);

  always_ff @(posedge bus_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      out_valid  <= 1'b0;
      out_sample <= '0;
    end
    else if (clear)
    begin
      out_valid <= 1'b0;
    end
    else
    begin
      out_valid <= in_valid;
      // Sum wraps at the sample width
      if (in_valid)
      begin
        out_sample <= in_sample + offset;
      end
    end
  end

endmodule

//--- rtl/stream_chain.sv
`timescale 1ns/1ps
`include "stream_consts.svh"

module stream_chain (
  input  logic                 bus_clk,
  input  logic                 rst_n,
  input  logic                 w32_open,
  input  logic                 r32_open,
  input  logic                 w32_wren,
  input  stream_pkg::word_t    w32_data,
  input  logic                 r32_rden,
  input  stream_pkg::offsets_t offsets,
  output logic                 w32_full,
  output stream_pkg::word_t    r32_data,
  output logic                 r32_empty
);

  localparam int N_MID = `STREAM_STAGES - 1;

  stream_pkg::word_t   in_dout;
  logic                in_empty;
  logic                pacer_rd_en;
  logic                pacer_valid;
  stream_pkg::sample_t stage_in_sample [`STREAM_STAGES];
  logic                stage_in_valid [`STREAM_STAGES];
  stream_pkg::sample_t stage_out_sample [`STREAM_STAGES];
  logic                stage_out_valid [`STREAM_STAGES];
  // Almost-full of the FIFO that takes stage k output
  logic [`STREAM_STAGES-1:0] down_afull;
  stream_pkg::sample_t mid_dout [N_MID];
  logic [N_MID-1:0]    mid_rd_en;
  logic [N_MID-1:0]    mid_empty;
  logic [N_MID-1:0]    mid_full;
  stream_pkg::word_t   out_din;
  logic                out_wr_en;
  logic                out_full;

  sync_fifo #(.payload_t(stream_pkg::word_t), .DEPTH(`STREAM_FIFO_DEPTH)) i_in_fifo (
    .bus_clk(bus_clk), .rst_n(rst_n), .clear(!w32_open),
    .wr_en(w32_wren), .din(w32_data), .rd_en(pacer_rd_en),
    .dout(in_dout), .full(w32_full), .afull(), .empty(in_empty)
  );

  // Pacer also holds off while the first inter-stage FIFO is nearly full
  input_pacer i_pacer (
    .bus_clk(bus_clk), .rst_n(rst_n), .clear(!w32_open),
    .empty(in_empty || down_afull[0]), .rd_en(pacer_rd_en), .valid(pacer_valid)
  );

  assign stage_in_valid[0]  = pacer_valid;
  assign stage_in_sample[0] = in_dout[`STREAM_SAMPLE_W-1:0];

  for (genvar k = 0; k < `STREAM_STAGES; k++)
  begin : g_stage
    if (k > 0)
    begin : g_mid
      logic valid_q;

      sync_fifo #(.payload_t(stream_pkg::sample_t), .DEPTH(`STREAM_FIFO_DEPTH)) i_fifo (
        .bus_clk(bus_clk), .rst_n(rst_n), .clear(!r32_open),
        .wr_en(stage_out_valid[k-1]), .din(stage_out_sample[k-1]),
        .rd_en(mid_rd_en[k-1]), .dout(mid_dout[k-1]),
        .full(mid_full[k-1]), .afull(down_afull[k-1]), .empty(mid_empty[k-1])
      );

      assign mid_rd_en[k-1] = !mid_empty[k-1] && !down_afull[k];

      // Data comes out one cycle after the read
      always_ff @(posedge bus_clk or negedge rst_n)
      begin
        if (!rst_n)
          valid_q <= 1'b0;
        else if (!w32_open)
          valid_q <= 1'b0;
        else
          valid_q <= mid_rd_en[k-1];
      end

      assign stage_in_valid[k]  = valid_q;
      assign stage_in_sample[k] = mid_dout[k-1];
    end

    offset_stage i_stage (
      .bus_clk(bus_clk), .rst_n(rst_n), .clear(!w32_open),
      .in_valid(stage_in_valid[k]), .in_sample(stage_in_sample[k]),
      .offset(offsets[k]),
      .out_valid(stage_out_valid[k]), .out_sample(stage_out_sample[k])
    );
  end

  // Last sample goes out zero-extended to a host word
  assign out_wr_en = stage_out_valid[`STREAM_STAGES-1];
  assign out_din   = {{(`STREAM_WORD_W - `STREAM_SAMPLE_W){1'b0}},
                      stage_out_sample[`STREAM_STAGES-1]};

  sync_fifo #(.payload_t(stream_pkg::word_t), .DEPTH(`STREAM_FIFO_DEPTH)) i_out_fifo (
    .bus_clk(bus_clk), .rst_n(rst_n), .clear(!r32_open),
    .wr_en(out_wr_en), .din(out_din), .rd_en(r32_rden),
    .dout(r32_data), .full(out_full), .afull(down_afull[`STREAM_STAGES-1]),
    .empty(r32_empty)
  );

endmodule

//--- rtl/stream_top.sv
`timescale 1ns/1ps
`include "stream_consts.svh"

module stream_top (
  input  logic                   bus_clk,
  input  logic                   rst_n,
  input  logic                   w32_open,
  input  logic                   w32_wren,
  input  stream_pkg::word_t      w32_data,
  input  logic                   r32_open,
  input  logic                   r32_rden,
  input  logic                   lite_wren,
  input  logic [`LITE_LANES-1:0] lite_wstrb,
  input  logic                   lite_rden,
  input  stream_pkg::word_t      lite_addr,
  input  stream_pkg::word_t      lite_wr_data,
  input  logic                   mem_wren,
  input  stream_pkg::byte_t      mem_wdata,
  input  logic                   mem_rden,
  input  stream_pkg::ram_addr_t  mem_addr,
  output logic                   w32_full,
  output stream_pkg::word_t      r32_data,
  output logic                   r32_empty,
  output stream_pkg::word_t      lite_rd_data,
  output stream_pkg::byte_t      mem_rdata
);

  stream_pkg::offsets_t offsets;

  lite_bus_if lite_bus ();

  // Byte address to word index
  assign lite_bus.wren    = lite_wren;
  assign lite_bus.wstrb   = lite_wstrb;
  assign lite_bus.rden    = lite_rden;
  assign lite_bus.addr    = lite_addr[`LITE_ADDR_LSB +: $bits(stream_pkg::lite_idx_t)];
  assign lite_bus.wr_data = lite_wr_data;
  assign lite_rd_data     = lite_bus.rd_data;

  lite_regs i_lite_regs (
    .bus_clk(bus_clk), .rst_n(rst_n), .bus(lite_bus.regs), .offsets(offsets)
  );

  byte_ram i_byte_ram (
    .bus_clk(bus_clk), .rst_n(rst_n), .wren(mem_wren), .wdata(mem_wdata),
    .rden(mem_rden), .addr(mem_addr), .rdata(mem_rdata)
  );

  stream_chain i_chain (
    .bus_clk(bus_clk), .rst_n(rst_n), .w32_open(w32_open), .r32_open(r32_open),
    .w32_wren(w32_wren), .w32_data(w32_data), .r32_rden(r32_rden),
    .offsets(offsets), .w32_full(w32_full), .r32_data(r32_data),
    .r32_empty(r32_empty)
  );

endmodule

//--- test/stream_assert.sv
`timescale 1ns/1ps
`include "stream_consts.svh"

module stream_assert (
  input logic                      bus_clk,
  input logic                      rst_n,
  input logic                      pacer_rd_en,
  input logic                      in_full,
  input logic                      in_empty,
  input logic [`STREAM_STAGES-2:0] mid_full,
  input logic [`STREAM_STAGES-2:0] mid_empty,
  input logic                      out_full,
  input logic                      out_empty,
  input logic                      out_wr_en
);

  int fail_count = 0;

  // Pacer leaves at least one idle cycle between reads
  a_pace: assert property (@(posedge bus_clk) disable iff (!rst_n)
    pacer_rd_en |=> !pacer_rd_en)
  else
  begin
    $error("pacer read the input FIFO on two cycles in a row");
    fail_count++;
  end

  a_flags: assert property (@(posedge bus_clk) disable iff (!rst_n)
    !(in_full && in_empty) && ((mid_full & mid_empty) == '0) && !(out_full && out_empty))
  else
  begin
    $error("a FIFO reported full and empty at once");
    fail_count++;
  end

  // Slack in the output FIFO must cover everything in flight
  a_out_wr: assert property (@(posedge bus_clk) disable iff (!rst_n)
    out_wr_en |-> !out_full)
  else
  begin
    $error("output FIFO written while full");
    fail_count++;
  end

endmodule

bind stream_chain stream_assert i_assert (
  .bus_clk(bus_clk), .rst_n(rst_n), .pacer_rd_en(pacer_rd_en),
  .in_full(w32_full), .in_empty(in_empty), .mid_full(mid_full), .mid_empty(mid_empty),
  .out_full(out_full), .out_empty(r32_empty), .out_wr_en(out_wr_en)
);

//--- test/stream_tb.sv
`timescale 1ns/1ps
`include "stream_consts.svh"

module stream_tb;

  localparam int CLK_HALF   = 2;
  localparam int N_LITE     = 24;
  localparam int N_RAM      = 24;
  localparam int N_STREAM   = 40;
  // Rough capacity of the whole chain in words
  localparam int BP_WORDS   = `STREAM_FIFO_DEPTH * (`STREAM_STAGES + 1);
  localparam int N_FILL_MAX = 2 * BP_WORDS * `STREAM_PACE;
  localparam int STALL_RUN  = 2 * `STREAM_PACE;
  localparam int WATCH_NS   = ((N_STREAM + 4 * BP_WORDS) * `STREAM_PACE + 2000) * 2 * CLK_HALF;

  logic                   bus_clk = 1'b0;
  logic                   rst_n;
  logic                   w32_open;
  logic                   w32_wren;
  logic [31:0]            w32_data;
  logic                   r32_open;
  logic                   r32_rden;
  logic                   lite_wren;
  logic [`LITE_LANES-1:0] lite_wstrb;
  logic                   lite_rden;
  logic [31:0]            lite_addr;
  logic [31:0]            lite_wr_data;
  logic                   mem_wren;
  logic [7:0]             mem_wdata;
  logic                   mem_rden;
  logic [4:0]             mem_addr;
  logic                   w32_full;
  logic [31:0]            r32_data;
  logic                   r32_empty;
  logic [31:0]            lite_rd_data;
  logic [7:0]             mem_rdata;

  logic [31:0] lite_model [`LITE_ENTRIES];
  logic [7:0]  ram_model [`RAM_BYTES];
  logic [31:0] exp_q [$];
  int          err_count = 0;
  int          n_checks = 0;
  int          n_tests = 0;
  int          n_bad_tests = 0;
  int          n_written = 0;
  int          n_read = 0;

  stream_top i_dut (
    .bus_clk(bus_clk), .rst_n(rst_n),
    .w32_open(w32_open), .w32_wren(w32_wren), .w32_data(w32_data),
    .r32_open(r32_open), .r32_rden(r32_rden),
    .lite_wren(lite_wren), .lite_wstrb(lite_wstrb), .lite_rden(lite_rden),
    .lite_addr(lite_addr), .lite_wr_data(lite_wr_data),
    .mem_wren(mem_wren), .mem_wdata(mem_wdata), .mem_rden(mem_rden), .mem_addr(mem_addr),
    .w32_full(w32_full), .r32_data(r32_data), .r32_empty(r32_empty),
    .lite_rd_data(lite_rd_data), .mem_rdata(mem_rdata)
  );

  always #CLK_HALF bus_clk = ~bus_clk;

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp)
    begin
      err_count++;
      $display("** Error: %0t: %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Expected output word from the input word and the stage offsets
  function automatic logic [31:0] ref_word(input logic [31:0] w);
    logic [15:0] acc;
    acc = w[15:0];
    for (int k = 0; k < `STREAM_STAGES; k++)
      acc = acc + lite_model[k][15:0];
    return {16'd0, acc};
  endfunction

  task automatic lite_write(input logic [4:0] idx, input logic [3:0] strb,
                            input logic [31:0] data);
    @(negedge bus_clk);
    lite_wren    = 1'b1;
    lite_wstrb   = strb;
    lite_addr    = {25'd0, idx, 2'b00};
    lite_wr_data = data;
    for (int l = 0; l < `LITE_LANES; l++)
    begin
      if (strb[l])
        lite_model[idx][8*l +: 8] = data[8*l +: 8];
    end
    @(negedge bus_clk);
    lite_wren = 1'b0;
  endtask

  task automatic lite_read_check(input logic [4:0] idx);
    @(negedge bus_clk);
    lite_rden = 1'b1;
    lite_addr = {25'd0, idx, 2'b00};
    @(negedge bus_clk);
    lite_rden = 1'b0;
    check($sformatf("lite entry %0d", idx), lite_rd_data, lite_model[idx]);
  endtask

  task automatic ram_write(input logic [4:0] addr, input logic [7:0] data);
    @(negedge bus_clk);
    mem_wren  = 1'b1;
    mem_addr  = addr;
    mem_wdata = data;
    ram_model[addr] = data;
    @(negedge bus_clk);
    mem_wren = 1'b0;
  endtask

  task automatic ram_read_check(input logic [4:0] addr);
    @(negedge bus_clk);
    mem_rden = 1'b1;
    mem_addr = addr;
    @(negedge bus_clk);
    mem_rden = 1'b0;
    check($sformatf("ram byte %0d", addr), 32'(mem_rdata), 32'(ram_model[addr]));
  endtask

  // One streaming cycle that writes and reads only where the flags allow
  task automatic stream_step(input bit allow_wr, input bit allow_rd);
    logic [31:0] w;
    @(negedge bus_clk);
    w32_wren = 1'b0;
    r32_rden = 1'b0;
    if (allow_wr && !w32_full)
    begin
      w = $urandom();
      w32_wren = 1'b1;
      w32_data = w;
      exp_q.push_back(ref_word(w));
      n_written++;
    end
    if (allow_rd && !r32_empty)
      r32_rden = 1'b1;
  endtask

  task automatic end_test(input string name, input int errs_before);
    n_tests++;
    if (err_count == errs_before)
      $display("test %0d %s: pass", n_tests, name);
    else
    begin
      n_bad_tests++;
      $display("test %0d %s: FAIL, %0d errors", n_tests, name, err_count - errs_before);
    end
  endtask

  // Read results land on r32_data by the falling edge after the read
  initial
  begin
    logic [31:0] exp_w;
    forever
    begin
      @(posedge bus_clk);
      if (rst_n && r32_rden)
      begin
        @(negedge bus_clk);
        n_read++;
        if (exp_q.size() == 0)
        begin
          err_count++;
          $display("stream word %h came out with no word left to expect", r32_data);
        end
        else
        begin
          exp_w = exp_q.pop_front();
          check($sformatf("stream word %0d", n_read), r32_data, exp_w);
        end
      end
    end
  end

  initial
  begin
    #(WATCH_NS);
    $display("watchdog expired after %0d ns, the stream did not finish", WATCH_NS);
    $display("tests failed");
    $finish;
  end

  initial
  begin
    logic [31:0] rnd;
    logic [31:0] data;
    bit          written [`RAM_BYTES];
    int          mark;
    int          base;
    int          steps;
    int          full_run;
    int          n_assert;
    rnd = $urandom(32'heccf5cf4);
    rst_n        = 1'b0;
    w32_open     = 1'b1;
    r32_open     = 1'b1;
    w32_wren     = 1'b0;
    w32_data     = '0;
    r32_rden     = 1'b0;
    lite_wren    = 1'b0;
    lite_wstrb   = '0;
    lite_rden    = 1'b0;
    lite_addr    = '0;
    lite_wr_data = '0;
    mem_wren     = 1'b0;
    mem_wdata    = '0;
    mem_rden     = 1'b0;
    mem_addr     = '0;
    for (int i = 0; i < `LITE_ENTRIES; i++)
      lite_model[i] = '0;
    for (int i = 0; i < `RAM_BYTES; i++)
      written[i] = 1'b0;
    repeat (3) @(posedge bus_clk);
    @(negedge bus_clk);
    rst_n = 1'b1;

    mark = err_count;
    check("r32_empty after reset", 32'(r32_empty), 32'd1);
    check("w32_full after reset", 32'(w32_full), 32'd0);
    check("lite_rd_data after reset", lite_rd_data, 32'd0);
    check("mem_rdata after reset", 32'(mem_rdata), 32'd0);
    end_test("reset state", mark);

    mark = err_count;
    repeat (N_LITE)
    begin
      rnd  = $urandom();
      data = $urandom();
      lite_write(rnd[4:0], rnd[11:8], data);
    end
    for (int i = 0; i < `LITE_ENTRIES; i++)
      lite_read_check(5'(i));
    end_test("lite strobed writes", mark);

    mark = err_count;
    repeat (N_RAM)
    begin
      rnd = $urandom();
      ram_write(rnd[4:0], rnd[15:8]);
      written[rnd[4:0]] = 1'b1;
    end
    for (int i = 0; i < `RAM_BYTES; i++)
    begin
      if (written[i])
        ram_read_check(5'(i));
    end
    end_test("ram readback", mark);

    mark = err_count;
    for (int k = 0; k < `STREAM_STAGES; k++)
    begin
      data = $urandom();
      lite_write(5'(k), 4'hf, data);
    end
    base = n_written;
    while (n_written < base + N_STREAM)
      stream_step(1'b1, 1'b1);
    while (n_read < n_written)
      stream_step(1'b0, 1'b1);
    check("words left after stream", 32'(exp_q.size()), 32'd0);
    end_test("stream with offsets", mark);

    // Fill without reading until the input stays full past a pacing period
    mark = err_count;
    steps    = 0;
    full_run = 0;
    while (full_run < STALL_RUN && steps < N_FILL_MAX)
    begin
      stream_step(1'b1, 1'b0);
      steps++;
      if (w32_full)
        full_run++;
      else
        full_run = 0;
    end
    if (full_run < STALL_RUN)
    begin
      err_count++;
      $display("back-pressure never stalled the chain, w32_full did not stay high");
    end
    while (n_read < n_written)
      stream_step(1'b0, 1'b1);
    @(negedge bus_clk);
    r32_rden = 1'b0;
    check("words left after drain", 32'(exp_q.size()), 32'd0);
    check("r32_empty after drain", 32'(r32_empty), 32'd1);
    check("w32_full after drain", 32'(w32_full), 32'd0);
    end_test("back-pressure", mark);

    n_assert = i_dut.i_chain.i_assert.fail_count;
    $display("summary: %0d tests run, %0d failing, %0d checks, %0d errors, %0d assertion errors",
             n_tests, n_bad_tests, n_checks, err_count, n_assert);
    if (err_count == 0 && n_assert == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

//--- flist.f
+incdir+rtl
rtl/stream_pkg.sv
rtl/lite_bus_if.sv
rtl/sync_fifo.sv
rtl/lite_regs.sv
rtl/byte_ram.sv
rtl/input_pacer.sv
rtl/offset_stage.sv
rtl/stream_chain.sv
rtl/stream_top.sv
test/stream_assert.sv
test/stream_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = stream_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = all tests passed

SOURCES = $(wildcard rtl/*.sv rtl/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q -x "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
